//--- Bender.yml
package:
  name: wrr_arbiter

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wrr_arb_pkg.sv
      - hdl/wrr_cfg_pkg.sv
      - hdl/wrr_arb_if.sv
      - hdl/wrr_arb_pick.sv
      - hdl/wrr_arb_state.sv
      - hdl/wrr_weight_table.sv
      - hdl/wrr_arbiter.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/wrr_arbiter_assert.sv
      - dv/wrr_arbiter_tb.sv

//--- dv/wrr_arbiter_assert.sv
// Concurrent checks on the arbiter ports and its round-robin index.
// Bound into every wrr_arbiter instance by the bind at the end of this file.
`include "wrr_macros.svh"

module wrr_arbiter_assert (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     accept,
  input logic                     cfg_valid,
  input logic [`WRR_NUM_REQS-1:0] reqs,
  input logic                     winner_v,
  input logic [`WRR_IDX_W-1:0]    winner,
  input logic [`WRR_IDX_W-1:0]    index_f
);

  timeunit 1ns;
  timeprecision 100ps;

  // Running count of failed assertions
  int fail_count = 0;

  // A winner exists exactly when somebody requests, reset or not
  winner_valid_a: assert property (@(posedge clk) winner_v == (|reqs))
    else begin
      $error("winner_v differs from the OR of the request vector");
      fail_count++;
    end

  // The granted requester must be one that asked
  winner_requests_a: assert property (@(posedge clk) winner_v |-> reqs[winner])
    else begin
      $error("winner points at a requester without a request");
      fail_count++;
    end

  // With no grant taken and no command, the index cannot move
  index_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!accept && !cfg_valid) |=> $stable(index_f))
    else begin
      $error("round-robin index moved without accept or a command");
      fail_count++;
    end

endmodule

bind wrr_arbiter wrr_arbiter_assert wrr_arbiter_assert_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .accept    (accept),
  .cfg_valid (cfg_valid),
  .reqs      (reqs),
  .winner_v  (winner_v),
  .winner    (winner),
  .index_f   (arb_if.index_f)
);

//--- dv/wrr_arbiter_tb.sv
// Self-checking testbench for the weighted round-robin arbiter.
// A reference model follows the pick rule and a compare process checks the DUT
// every cycle just before the rising edge. Compile with tb.f.
`include "wrr_macros.svh"

module wrr_arbiter_tb
  import wrr_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQS     = `WRR_NUM_REQS;
  localparam int IW           = `WRR_IDX_W;
  localparam int WW           = `WRR_WEIGHT_W;
  localparam int CW           = NUM_REQS * WW;
  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int SETTLE_DELAY = 8;
  localparam int CHECK_LEAD   = 5;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_CYCLES = 1000;
  // Roughly twice the summed length of all tests
  localparam int TIMEOUT_CYCLES = 3000;

  logic                clk;
  logic                rst_n;
  logic                accept;
  logic                cfg_valid;
  logic [NUM_REQS-1:0] reqs;
  logic [1:0]          cfg_op;
  logic [IW-1:0]       cfg_id;
  logic [WW-1:0]       cfg_weight;
  logic                winner_v;
  logic [IW-1:0]       winner;
  logic                winner_in_seq;

  // Reference model state, count and weight of requester n sit in slice n
  logic [IW-1:0] m_index;
  logic [CW-1:0] m_counts;
  logic [CW-1:0] m_weights;

  logic [31:0] lfsr_state;
  string       test_name;
  int          error_count;
  int          cycle_count;

  wrr_arbiter wrr_arbiter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept        (accept),
    .cfg_valid     (cfg_valid),
    .reqs          (reqs),
    .cfg_op        (cfg_op),
    .cfg_id        (cfg_id),
    .cfg_weight    (cfg_weight),
    .winner_v      (winner_v),
    .winner        (winner),
    .winner_in_seq (winner_in_seq)
  );

  always #(HALF_PERIOD) clk = ~clk;

  task automatic end_in_failure();
    error_count++;
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
      end_in_failure();
    end
  endtask

  // The bound checker counts its own failures
  task automatic check_bound_assertions();
    assert (wrr_arbiter_i.wrr_arbiter_assert_i.fail_count == 0) else begin
      $display("A bound assertion on the DUT ports or state failed");
      end_in_failure();
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [NUM_REQS-1:0] nonzero_reqs();
    logic [NUM_REQS-1:0] r;
    r = '0;
    while (r == '0) begin
      r = NUM_REQS'(take_bits(NUM_REQS));
    end
    return r;
  endfunction

  function automatic int lowest_set(input logic [NUM_REQS-1:0] v);
    int pos;
    pos = -1;
    for (int i = 0; i < NUM_REQS; i++) begin
      if (pos < 0 && v[i]) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  // Pick rule: first requester at or above the index, wrapping round.
  // A zero count moves the index past the winner and reloads its weight,
  // otherwise the index parks on the winner and its count drops by one
  function automatic void ref_pick(
    input  logic [IW-1:0]       index,
    input  logic [CW-1:0]       counts,
    input  logic [CW-1:0]       weights,
    input  logic [NUM_REQS-1:0] req_v,
    output logic                exp_v,
    output logic [IW-1:0]       exp_winner,
    output logic                exp_seq,
    output logic [IW-1:0]       nxt_index,
    output logic [CW-1:0]       nxt_counts
  );
    int            cand;
    logic [WW-1:0] cnt;
    exp_v      = 1'b0;
    exp_winner = '0;
    for (int k = 0; k < NUM_REQS; k++) begin
      cand = (int'(index) + k) % NUM_REQS;
      if (!exp_v && req_v[cand]) begin
        exp_v      = 1'b1;
        exp_winner = IW'(cand);
      end
    end
    exp_seq    = exp_v && (exp_winner == index);
    nxt_index  = index;
    nxt_counts = counts;
    if (exp_v) begin
      cnt = counts[exp_winner*WW +: WW];
      if (cnt == '0) begin
        nxt_index                       = IW'((int'(exp_winner) + 1) % NUM_REQS);
        nxt_counts[exp_winner*WW +: WW] = weights[exp_winner*WW +: WW];
      end else begin
        nxt_index                       = exp_winner;
        nxt_counts[exp_winner*WW +: WW] = cnt - WW'(1);
      end
    end
  endfunction

  task automatic reset_model();
    m_index  = '0;
    m_counts = '0;
    for (int n = 0; n < NUM_REQS; n++) begin
      m_weights[n*WW +: WW] = WW'(`WRR_WEIGHT_RESET);
    end
  endtask

  // Checks the outputs against the model, then steps the model the way the
  // DUT registers will move on the coming edge
  task automatic compare_and_advance();
    logic          exp_v;
    logic [IW-1:0] exp_winner;
    logic          exp_seq;
    logic [IW-1:0] nxt_index;
    logic [CW-1:0] nxt_counts;
    ref_pick(m_index, m_counts, m_weights, reqs, exp_v, exp_winner, exp_seq,
             nxt_index, nxt_counts);
    check_value("winner_v", exp_v, winner_v);
    if (exp_v) begin
      check_value("winner", exp_winner, winner);
    end
    check_value("winner_in_seq", exp_seq, winner_in_seq);
    if (!rst_n) begin
      reset_model();
    end else begin
      // Clear beats an accept in the same cycle
      if (cfg_valid && cfg_op == CFG_CLEAR) begin
        m_index  = '0;
        m_counts = '0;
      end else if (accept && exp_v) begin
        m_index  = nxt_index;
        m_counts = nxt_counts;
      end
      // The reload above already used the old weight
      if (cfg_valid && cfg_op == CFG_SET_WEIGHT) begin
        m_weights[cfg_id*WW +: WW] = cfg_weight;
      end
    end
  endtask

  always begin
    @(posedge clk);
    #(2 * HALF_PERIOD - CHECK_LEAD);
    check_bound_assertions();
    compare_and_advance();
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_in_failure();
    end
  end

  task automatic wait_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic settle();
    #(SETTLE_DELAY);
  endtask

  // Holds one command for a single cycle, then returns the port to idle
  task automatic send_cfg(input cfg_op_e op, input logic [IW-1:0] id,
                          input logic [WW-1:0] weight);
    cfg_valid  = 1'b1;
    cfg_op     = op;
    cfg_id     = id;
    cfg_weight = weight;
    wait_cycle();
    cfg_valid  = 1'b0;
    cfg_op     = CFG_NOP;
  endtask

  // Every test task starts and ends at a drive point just after an edge
  task automatic first_request_after_reset();
    logic [NUM_REQS-1:0] r;
    test_name = "first_request_after_reset";
    reqs      = '0;
    accept    = 1'b0;
    repeat (3) begin
      settle();
      check_value("winner_v", 1'b0, winner_v);
      wait_cycle();
    end
    r    = nonzero_reqs();
    reqs = r;
    settle();
    check_value("winner_v", 1'b1, winner_v);
    check_value("winner", lowest_set(r), winner);
    check_value("winner_in_seq", lowest_set(r) == 0, winner_in_seq);
    wait_cycle();
  endtask

  task automatic weighted_rounds();
    int exp_q[$];
    int w;
    test_name = "weighted_rounds";
    reqs      = '0;
    accept    = 1'b0;
    // 5n+3 modulo the weight range gives every requester a different weight
    for (int n = 0; n < NUM_REQS; n++) begin
      send_cfg(CFG_SET_WEIGHT, IW'(n), WW'((5 * n + 3) % (1 << WW)));
    end
    send_cfg(CFG_CLEAR, '0, '0);
    // Counts start at zero, so the first round is one grant each
    for (int n = 0; n < NUM_REQS; n++) begin
      exp_q.push_back(n);
    end
    repeat (2) begin
      for (int n = 0; n < NUM_REQS; n++) begin
        w = (5 * n + 3) % (1 << WW);
        repeat (w + 1) exp_q.push_back(n);
      end
    end
    reqs   = '1;
    accept = 1'b1;
    while (exp_q.size() > 0) begin
      settle();
      check_value("winner", exp_q.pop_front(), winner);
      wait_cycle();
    end
    accept = 1'b0;
    reqs   = '0;
  endtask

  task automatic random_traffic();
    test_name = "random_traffic";
    repeat (RANDOM_CYCLES) begin
      // AND of two random bytes keeps the request vectors sparse
      reqs       = NUM_REQS'(take_bits(NUM_REQS) & take_bits(NUM_REQS));
      accept     = (take_bits(2) != 0);
      cfg_valid  = (take_bits(4) == 0);
      cfg_op     = cfg_valid ? CFG_SET_WEIGHT : CFG_NOP;
      cfg_id     = IW'(take_bits(IW));
      cfg_weight = WW'(take_bits(WW));
      wait_cycle();
    end
    cfg_valid = 1'b0;
    cfg_op    = CFG_NOP;
    accept    = 1'b0;
    reqs      = '0;
  endtask

  task automatic hold_without_accept();
    logic          exp_v;
    logic [IW-1:0] exp_winner;
    logic          exp_seq;
    logic [IW-1:0] nxt_index;
    logic [CW-1:0] nxt_counts;
    logic [IW-1:0] held_index;
    logic [CW-1:0] held_counts;
    test_name = "hold_without_accept";
    reqs      = nonzero_reqs();
    accept    = 1'b0;
    settle();
    held_index  = m_index;
    held_counts = m_counts;
    ref_pick(m_index, m_counts, m_weights, reqs, exp_v, exp_winner, exp_seq,
             nxt_index, nxt_counts);
    repeat (10) begin
      wait_cycle();
      settle();
      check_value("winner", exp_winner, winner);
      check_value("winner_in_seq", exp_seq, winner_in_seq);
      // The registered state must sit still while nothing is accepted
      check_value("index", held_index, wrr_arbiter_i.arb_if.index_f);
      check_value("counts", held_counts, wrr_arbiter_i.arb_if.count_f);
    end
    wait_cycle();
  endtask

  task automatic clear_mid_sequence();
    logic [NUM_REQS-1:0] r;
    int                  low;
    test_name = "clear_mid_sequence";
    reqs      = '1;
    accept    = 1'b1;
    repeat (13) wait_cycle();
    // Clear and accept in the same cycle
    cfg_valid = 1'b1;
    cfg_op    = CFG_CLEAR;
    wait_cycle();
    cfg_valid = 1'b0;
    cfg_op    = CFG_NOP;
    accept    = 1'b0;
    r         = nonzero_reqs();
    reqs      = r;
    low       = lowest_set(r);
    settle();
    check_value("winner", low, winner);
    check_value("winner_in_seq", low == 0, winner_in_seq);
    check_value("index", 0, wrr_arbiter_i.arb_if.index_f);
    wait_cycle();
    reqs = '0;
  endtask

  task automatic weight_rewrite();
    int starts[$];
    test_name = "weight_rewrite";
    send_cfg(CFG_SET_WEIGHT, IW'(3), WW'(2));
    reqs   = 8'h08;
    accept = 1'b1;
    repeat (10) wait_cycle();
    // Only the reload that ends the current turn sees the new weight
    cfg_valid  = 1'b1;
    cfg_op     = CFG_SET_WEIGHT;
    cfg_id     = IW'(3);
    cfg_weight = WW'(5);
    wait_cycle();
    cfg_valid = 1'b0;
    cfg_op    = CFG_NOP;
    // Each turn of the lone requester opens with one out-of-sequence grant
    for (int c = 0; c < 24; c++) begin
      settle();
      if (!winner_in_seq) begin
        starts.push_back(c);
      end
      wait_cycle();
    end
    assert (starts.size() >= 2) else begin
      $display("Fewer than two turns of requester 3 were seen after the weight change");
      end_in_failure();
    end
    check_value("turn length", 5 + 1, starts[starts.size()-1] - starts[starts.size()-2]);
    accept = 1'b0;
    reqs   = '0;
  endtask

  initial begin : stimulus
    clk         = 1'b0;
    rst_n       = 1'b0;
    accept      = 1'b0;
    cfg_valid   = 1'b0;
    reqs        = '0;
    cfg_op      = CFG_NOP;
    cfg_id      = '0;
    cfg_weight  = '0;
    lfsr_state  = 32'h5b82;
    error_count = 0;
    test_name   = "reset";
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    first_request_after_reset();
    weighted_rounds();
    random_traffic();
    hold_without_accept();
    clear_mid_sequence();
    weight_rewrite();
    // Let the compare process see the last driven cycle
    repeat (2) wait_cycle();
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- hdl/wrr_arb_if.sv
// Link between the arbiter state registers and the combinational pick block.
// The state side owns the registered index and counts, the pick side returns the next values.
interface wrr_arb_if
  import wrr_arb_pkg::*;
();

  // Registered round-robin index and per-requester counts
  req_idx_t   index_f;
  count_arr_t count_f;

  // Values the state takes when a grant is accepted
  req_idx_t   index_nxt;
  count_arr_t count_nxt;

  // Grant acceptance as requested by the top level.
  // The pick block only advances the next values while it is high
  logic       update;

  modport state (
    output index_f,
    output count_f,
    input  index_nxt,
    input  count_nxt
  );

  modport pick (
    input  index_f,
    input  count_f,
    input  update,
    output index_nxt,
    output count_nxt
  );

endinterface

//--- hdl/wrr_arb_pick.sv
// Combinational weighted round-robin pick.
// Finds the winner from the registered index and computes the index and counts
// that follow once the grant is accepted.
`include "wrr_macros.svh"

module wrr_arb_pick
  import wrr_arb_pkg::*;
(
  input  req_vec_t  reqs,
  input  weight_t   weight,
  wrr_arb_if.pick   arb,
  output logic      winner_v,
  output req_idx_t  winner,
  output logic      winner_in_seq
);

  // Requests doubled so that a plain right shift acts as a rotate
  logic [2*`WRR_NUM_REQS-1:0] reqs_dbl;
  // Requests rotated so that bit 0 is the requester the index points at
  req_vec_t                   reqs_rot;
  // Distance from the index to the first requester found
  req_idx_t                   offset;
  // Remaining count of the current winner
  weight_t                    win_count;

  assign reqs_dbl = {reqs, reqs} >> arb.index_f;
  assign reqs_rot = reqs_dbl[`WRR_NUM_REQS-1:0];

  // Lowest set bit of the rotated vector.
  // Scanning downward lets the lowest hit overwrite any higher one
  always_comb begin
    offset = '0;
    for (int i = `WRR_NUM_REQS - 1; i >= 0; i--) begin
      if (reqs_rot[i]) begin
        offset = req_idx_t'(i);
      end
    end
  end

  // Any request at all gives a valid winner
  assign winner_v = |reqs;

  // Index width equals log2 of the requester count, so the sum wraps by itself
  assign winner = arb.index_f + offset;

  assign win_count = arb.count_f[winner];

  // The winner is in sequence when the index already pointed at it.
  // That happens while a requester works through its extra grants
  assign winner_in_seq = winner_v && (winner == arb.index_f);

  // Next index and counts.
  // Nothing moves unless there is a winner and the top asks for an update
  always_comb begin
    arb.index_nxt = arb.index_f;
    arb.count_nxt = arb.count_f;
    if (winner_v && arb.update) begin
      if (win_count == '0) begin
        // Turn used up, so move past the winner and reload its count for next time
        arb.index_nxt         = winner + req_idx_t'(1);
        arb.count_nxt[winner] = weight;
      end else begin
        // Extra grants left, so the index stays on the winner
        arb.index_nxt         = winner;
        arb.count_nxt[winner] = win_count - weight_t'(1);
      end
    end
  end

endmodule

//--- hdl/wrr_arb_pkg.sv
// Data types shared by the arbitration datapath.
// Import it into any block that handles requests, requester numbers, weights or counts.
`include "wrr_macros.svh"

package wrr_arb_pkg;

  // One request bit per requester, bit n belongs to requester n
  typedef logic [`WRR_NUM_REQS-1:0] req_vec_t;

  // A requester number, also used for the round-robin index
  typedef logic [`WRR_IDX_W-1:0] req_idx_t;

  // A programmed weight or a remaining count of extra grants
  typedef logic [`WRR_WEIGHT_W-1:0] weight_t;

  // Counts for all requesters in one packed vector.
  // Element n holds the remaining count of requester n
  typedef weight_t [`WRR_NUM_REQS-1:0] count_arr_t;

endpackage

//--- hdl/wrr_arb_state.sv
// Registered round-robin index and per-requester counts.
// Loads the values from the pick block on an accepted grant and clears on CFG_CLEAR.
module wrr_arb_state
  import wrr_cfg_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          accept,
  input  logic          winner_v,
  input  cfg_cmd_t      cfg,
  input  logic          cfg_valid,
  wrr_arb_if.state      arb
);

  // Clear command from the configuration port
  logic clear;
  // A grant is being taken this cycle
  logic load;

  assign clear = cfg_valid && (cfg.op == CFG_CLEAR);

  // Accept without a winner means nobody was granted, so nothing changes
  assign load = accept && winner_v;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arb.index_f <= '0;
      arb.count_f <= '0;
    end else if (clear) begin
      // Clear wins over a grant accepted in the same cycle
      arb.index_f <= '0;
      arb.count_f <= '0;
    end else if (load) begin
      arb.index_f <= arb.index_nxt;
      arb.count_f <= arb.count_nxt;
    end
  end

endmodule

//--- hdl/wrr_arbiter.sv
// Weighted round-robin arbiter for eight requesters.
// Requests go in, the winner comes out in the same cycle, and accept commits the grant.
// The weight table and a clear are reached through the configuration ports.
`include "wrr_macros.svh"

module wrr_arbiter
  import wrr_arb_pkg::*;
  import wrr_cfg_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      accept,
  input  logic                      cfg_valid,
  input  logic [`WRR_NUM_REQS-1:0]  reqs,
  input  logic [1:0]                cfg_op,
  input  logic [`WRR_IDX_W-1:0]     cfg_id,
  input  logic [`WRR_WEIGHT_W-1:0]  cfg_weight,
  output logic                      winner_v,
  output logic [`WRR_IDX_W-1:0]     winner,
  output logic                      winner_in_seq
);

  // Configuration fields packed into one command
  cfg_cmd_t cfg;
  // Weight of the current winner, looked up in the table
  weight_t  cur_weight;

  assign cfg.op     = cfg_op_e'(cfg_op);
  assign cfg.id     = cfg_id;
  assign cfg.weight = cfg_weight;

  // Index and counts between the state registers and the pick block
  wrr_arb_if arb_if ();

  assign arb_if.update = accept;

  wrr_arb_pick wrr_arb_pick_i (
    .reqs          (reqs),
    .weight        (cur_weight),
    .arb           (arb_if.pick),
    .winner_v      (winner_v),
    .winner        (winner),
    .winner_in_seq (winner_in_seq)
  );

  wrr_arb_state wrr_arb_state_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .winner_v  (winner_v),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .arb       (arb_if.state)
  );

  // Read address is the winner, so the reload weight is ready in the same cycle
  wrr_weight_table wrr_weight_table_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .rd_idx    (winner),
    .rd_weight (cur_weight)
  );

endmodule

//--- hdl/wrr_cfg_pkg.sv
// Configuration command types for the arbiter.
// The weight table and the state block decode the same command and act on their own opcodes.
`include "wrr_macros.svh"

package wrr_cfg_pkg;

  import wrr_arb_pkg::*;

  // Configuration opcodes.
  // CFG_NOP is harmless, so an idle port can carry any value in the other fields
  typedef enum logic [1:0] {
    CFG_NOP        = 2'd0,
    CFG_SET_WEIGHT = 2'd1,
    CFG_CLEAR      = 2'd2
  } cfg_op_e;

  // A full command as it travels inside the design.
  // The id and weight fields only matter for CFG_SET_WEIGHT
  typedef struct packed {
    cfg_op_e  op;
    req_idx_t id;
    weight_t  weight;
  } cfg_cmd_t;

endpackage

//--- hdl/wrr_macros.svh
// Sizing constants for the weighted round-robin arbiter.
// Include this before any package or module that needs the requester count or widths.
`ifndef WRR_MACROS_SVH
`define WRR_MACROS_SVH

// Number of requesters that compete for a grant
`define WRR_NUM_REQS 8

// Width of a requester number, enough to address every requester
`define WRR_IDX_W 3

// Width of a weight, which is also the width of a remaining-grant count
`define WRR_WEIGHT_W 3

// Weight held by every table entry after reset.
// With weight 0 every requester gets a single grant per turn
`define WRR_WEIGHT_RESET 0

`endif

//--- hdl/wrr_weight_table.sv
// Per-requester weight table.
// The configuration port writes an entry with CFG_SET_WEIGHT, and the current
// winner reads its own weight without delay.
`include "wrr_macros.svh"

module wrr_weight_table
  import wrr_arb_pkg::*;
  import wrr_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  cfg_cmd_t cfg,
  input  logic     cfg_valid,
  input  req_idx_t rd_idx,
  output weight_t  rd_weight
);

  // One weight per requester
  weight_t weights [`WRR_NUM_REQS];

  // Write strobe for the entry named in the command
  logic wr_en;

  assign wr_en = cfg_valid && (cfg.op == CFG_SET_WEIGHT);

  // A written weight shows on the read port from the next cycle on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `WRR_NUM_REQS; i++) begin
        weights[i] <= weight_t'(`WRR_WEIGHT_RESET);
      end
    end else if (wr_en) begin
      weights[cfg.id] <= cfg.weight;
    end
  end

  // Read port, addressed by the winner of the current cycle.
  // The weight only reaches the next counts, so there is no loop back into the pick
  assign rd_weight = weights[rd_idx];

endmodule

//--- tb.f
+incdir+hdl
hdl/wrr_arb_pkg.sv
hdl/wrr_cfg_pkg.sv
hdl/wrr_arb_if.sv
hdl/wrr_arb_pick.sv
hdl/wrr_arb_state.sv
hdl/wrr_weight_table.sv
hdl/wrr_arbiter.sv
dv/wrr_arbiter_assert.sv
dv/wrr_arbiter_tb.sv
